//--- luma_pkg.sv
/*
  shared constants and types for the luma datapath
  coef_r + coef_g + coef_b must stay at 256 so the rounded sum fits term_w bits
*/
package luma_pkg;

  // ------------------------------
  // widths
  // ------------------------------
  // one weighted term, 8-bit channel times an 8-bit coefficient
  localparam int term_w = 16;

  // ------------------------------
  // BT.601 weights, scaled by 256
  // ------------------------------
  localparam int unsigned coef_r = 77;
  localparam int unsigned coef_g = 150;
  localparam int unsigned coef_b = 29;

  // half an lsb of the final shift by 8
  localparam int unsigned round_bias = 128;

  // ------------------------------
  // payload types
  // ------------------------------
  // three weighted terms, r in the upper bits
  typedef struct packed {
    logic [term_w-1:0] r_term;
    logic [term_w-1:0] g_term;
    logic [term_w-1:0] b_term;
  } term_t;

  // one input pixel, 8 bits per channel
  typedef struct packed {
    logic [7:0] r;
    logic [7:0] g;
    logic [7:0] b;
  } pix_t;

endpackage

//--- term_if.sv
/*
  valid/ready link that carries the three weighted terms
  the sink owns ready, the source owns valid and the terms
*/
interface term_if;
  import luma_pkg::*;

  // handshake
  logic valid;
  logic ready;

  // payload, one field per channel
  logic [term_w-1:0] r_term;
  logic [term_w-1:0] g_term;
  logic [term_w-1:0] b_term;

  // producing side
  modport source (
    output valid,
    output r_term,
    output g_term,
    output b_term,
    input  ready
  );

  // consuming side
  modport sink (
    input  valid,
    input  r_term,
    input  g_term,
    input  b_term,
    output ready
  );

endinterface

//--- rgb_coeff_mult.sv
/*
  weights R, G and B by the luma coefficients
  q.ready acts as clock enable, the whole pipeline freezes while it is low
  MULT_LAT = 0 gives a purely combinational path
  BYPASS zero-extends the raw channels, for debug only
*/
module rgb_coeff_mult #(
  parameter int unsigned MULT_LAT = 2,
  parameter bit          USE_DSP  = 1'b0,
  parameter bit          BYPASS   = 1'b0
) (
  input  logic           clk,
  input  logic           rst,
  input  logic           in_valid,
  input  luma_pkg::pix_t in_pix,
  term_if.source         q
);
  import luma_pkg::*;

  // ------------------------------
  // stage 0, combinational terms
  // ------------------------------
  term_t t0;

  // constant multiply built from shifted copies of x
  // one adder per set bit of coef, the loop folds away at elaboration
  function automatic logic [term_w-1:0] shift_add(input logic [7:0] x,
                                                  input int unsigned coef);
    logic [term_w-1:0] acc;
    acc = '0;
    for (int i = 0; i < 8; i++) begin
      if (coef[i]) begin
        acc = acc + (term_w'(x) << i);
      end
    end
    return acc;
  endfunction

  always_comb begin
    if (BYPASS) begin
      // raw channels, no weighting
      t0.r_term = term_w'(in_pix.r);
      t0.g_term = term_w'(in_pix.g);
      t0.b_term = term_w'(in_pix.b);
    end else if (USE_DSP) begin
      // plain products, left to the tool to map onto multipliers
      t0.r_term = term_w'(in_pix.r) * term_w'(coef_r);
      t0.g_term = term_w'(in_pix.g) * term_w'(coef_g);
      t0.b_term = term_w'(in_pix.b) * term_w'(coef_b);
    end else begin
      // shift-add, no multiplier needed
      t0.r_term = shift_add(in_pix.r, coef_r);
      t0.g_term = shift_add(in_pix.g, coef_g);
      t0.b_term = shift_add(in_pix.b, coef_b);
    end
  end

  // ------------------------------
  // enable-gated delay line
  // ------------------------------
  generate
    if (MULT_LAT == 0) begin : g_comb
      // straight through, valid follows the input in the same cycle
      assign q.valid  = in_valid;
      assign q.r_term = t0.r_term;
      assign q.g_term = t0.g_term;
      assign q.b_term = t0.b_term;
    end else begin : g_pipe
      logic [MULT_LAT-1:0] v_pipe;
      term_t               t_pipe [MULT_LAT];

      // valid bits, cleared by reset
      always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
          v_pipe <= '0;
        end else if (q.ready) begin
          v_pipe[0] <= in_valid;
          for (int k = 1; k < MULT_LAT; k++) begin
            v_pipe[k] <= v_pipe[k-1];
          end
        end
      end

      // term registers move in step with the valid bits
      always_ff @(posedge clk) begin
        if (q.ready) begin
          t_pipe[0] <= t0;
          for (int k = 1; k < MULT_LAT; k++) begin
            t_pipe[k] <= t_pipe[k-1];
          end
        end
      end

      // last stage drives the link
      assign q.valid  = v_pipe[MULT_LAT-1];
      assign q.r_term = t_pipe[MULT_LAT-1].r_term;
      assign q.g_term = t_pipe[MULT_LAT-1].g_term;
      assign q.b_term = t_pipe[MULT_LAT-1].b_term;
    end
  endgenerate

endmodule

//--- term_fifo.sv
/*
  synchronous FIFO between the multiplier and the adder
  FIFO_DEPTH must be a power of two, 2 or more
  write ready is plain not-full, read valid is not-empty
  head is read combinationally, a push shows up one cycle later
*/
module term_fifo #(
  parameter type         payload_t  = luma_pkg::term_t,
  parameter int unsigned FIFO_DEPTH = 4
) (
  input  logic   clk,
  input  logic   rst,
  term_if.sink   wr,
  term_if.source rd
);

  // ------------------------------
  // pointers and flags
  // ------------------------------
  localparam int unsigned addr_w = $clog2(FIFO_DEPTH);

  // extra msb tells a full FIFO from an empty one
  logic [addr_w:0] wr_ptr;
  logic [addr_w:0] rd_ptr;

  logic full;
  logic empty;
  logic push;
  logic pop;

  // storage
  payload_t mem [FIFO_DEPTH];
  payload_t wr_data;
  payload_t rd_data;

  // same slot, different lap means full
  assign full  = (wr_ptr[addr_w] != rd_ptr[addr_w]) &&
                 (wr_ptr[addr_w-1:0] == rd_ptr[addr_w-1:0]);
  assign empty = (wr_ptr == rd_ptr);

  // handshakes on both sides
  assign wr.ready = !full;
  assign rd.valid = !empty;
  assign push     = wr.valid && wr.ready;
  assign pop      = rd.valid && rd.ready;

  // ------------------------------
  // payload packing
  // ------------------------------
  // interface fields into the packed payload, r in the upper bits
  assign wr_data = payload_t'({wr.r_term, wr.g_term, wr.b_term});

  // head entry back out to the fields
  assign rd_data = mem[rd_ptr[addr_w-1:0]];
  assign {rd.r_term, rd.g_term, rd.b_term} = rd_data;

  // ------------------------------
  // storage and pointer update
  // ------------------------------
  // array write, no reset on the data
  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr[addr_w-1:0]] <= wr_data;
    end
  end

  // write pointer
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      wr_ptr <= '0;
    end else if (push) begin
      wr_ptr <= wr_ptr + 1'b1;
    end
  end

  // read pointer, independent of the write side
  // so push and pop may fall in the same cycle
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      rd_ptr <= '0;
    end else if (pop) begin
      rd_ptr <= rd_ptr + 1'b1;
    end
  end

endmodule

//--- luma_sum.sv
/*
  adds the weighted terms, rounds and keeps Y in a one-entry output register
  a pop in cycle t gives out_valid and out_y in cycle t+1
  the sum fits term_w bits because the coefficients add up to 256
*/
module luma_sum (
  input  logic       clk,
  input  logic       rst,
  term_if.sink       q,
  output logic       out_valid,
  input  logic       out_ready,
  output logic [7:0] out_y
);
  import luma_pkg::*;

  // ------------------------------
  // combinational sum
  // ------------------------------
  logic [term_w-1:0] sum;
  logic              pop;

  // worst case 255*256 + 128, still below 2**16
  assign sum = q.r_term + q.g_term + q.b_term + term_w'(round_bias);

  // ------------------------------
  // output register handshake
  // ------------------------------
  // take a new entry when the register is empty
  // or its content leaves this cycle
  assign q.ready = !out_valid || out_ready;
  assign pop     = q.valid && q.ready;

  // occupancy flag
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      out_valid <= 1'b0;
    end else if (q.ready) begin
      // refill or drain, whichever applies
      out_valid <= q.valid;
    end
  end

  // result byte, shift right by 8
  always_ff @(posedge clk) begin
    if (pop) begin
      out_y <= sum[15:8];
    end
  end

endmodule

//--- luma_top.sv
/*
  RGB to Y converter, one 8-bit Y per accepted pixel
  in_ready mirrors the multiplier enable and drops only while the FIFO is full
  latency is MULT_LAT + 2 cycles with no back-pressure
*/
module luma_top #(
  parameter int unsigned MULT_LAT   = 2,
  parameter int unsigned FIFO_DEPTH = 4,
  parameter bit          USE_DSP    = 1'b0,
  parameter bit          BYPASS     = 1'b0
) (
  input  logic       clk,
  input  logic       rst,
  // pixel input
  input  logic       in_valid,
  output logic       in_ready,
  input  logic [7:0] in_r,
  input  logic [7:0] in_g,
  input  logic [7:0] in_b,
  // luma output
  output logic       out_valid,
  input  logic       out_ready,
  output logic [7:0] out_y
);
  import luma_pkg::*;

  // ------------------------------
  // internal links
  // ------------------------------
  term_if mult_q ();
  term_if q_sum ();

  pix_t in_pix;

  // channels into one pixel word
  assign in_pix = '{r: in_r, g: in_g, b: in_b};

  // FIFO space is also the pipeline enable
  assign in_ready = mult_q.ready;

  // ------------------------------
  // datapath
  // ------------------------------
  // weighting stage
  rgb_coeff_mult #(
    .MULT_LAT (MULT_LAT),
    .USE_DSP  (USE_DSP),
    .BYPASS   (BYPASS)
  ) u_mult (
    .clk      (clk),
    .rst      (rst),
    .in_valid (in_valid),
    .in_pix   (in_pix),
    .q        (mult_q.source)
  );

  // decouples the frozen pipeline from the output
  term_fifo #(
    .payload_t  (term_t),
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_fifo (
    .clk (clk),
    .rst (rst),
    .wr  (mult_q.sink),
    .rd  (q_sum.source)
  );

  // sum, round and hold
  luma_sum u_sum (
    .clk       (clk),
    .rst       (rst),
    .q         (q_sum.sink),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_y     (out_y)
  );

endmodule

//--- tb_clkgen.sv
/*
  testbench clock and reset source
  reset is high from time 0 and drops on a rising edge after RST_CYCLES edges
*/
module tb_clkgen #(
  parameter int PERIOD     = 10,
  parameter int RST_CYCLES = 4
) (
  output logic clk,
  output logic rst
);

  // free running clock, first rising edge at PERIOD/2
  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  // reset released on a rising edge like any other driven input
  initial begin
    rst = 1'b1;
    repeat (RST_CYCLES) @(posedge clk);
    rst <= 1'b0;
  end

endmodule

//--- tb_luma_top.sv
/*
  testbench for the RGB to Y converter with its default parameters
  stimulus comes from a Galois LFSR with a fixed seed and is checked against a queue model
  inputs change and outputs are sampled on rising edges
  every wait loop has a cycle limit and a timeout skips the remaining tests
*/
module tb_luma_top;

  // DUT default parameters, also used for the back-pressure bound
  localparam int mult_lat   = 2;
  localparam int fifo_depth = 4;

  logic       clk;
  logic       rst;
  logic       in_valid;
  logic       in_ready;
  logic [7:0] in_r;
  logic [7:0] in_g;
  logic [7:0] in_b;
  logic       out_valid;
  logic       out_ready;
  logic [7:0] out_y;

  // scoreboard state
  logic [7:0]  model_q[$];
  logic [31:0] lfsr_state;
  string       test_name;
  int          acc_cnt;
  int          res_cnt;
  int          check_cnt;
  int          errors;
  bit          timed_out;

  tb_clkgen #(.PERIOD(10), .RST_CYCLES(4)) u_clkgen (
    .clk (clk),
    .rst (rst)
  );

  luma_top #(
    .MULT_LAT   (mult_lat),
    .FIFO_DEPTH (fifo_depth)
  ) dut (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_r      (in_r),
    .in_g      (in_g),
    .in_b      (in_b),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_y     (out_y)
  );

  // ------------------------------
  // random source and model
  // ------------------------------
  // right-shifting Galois LFSR stepped once per bit handed out
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] val;
    logic        b;
    val = '0;
    for (int i = 0; i < n; i++) begin
      b = lfsr_state[0];
      lfsr_state = lfsr_state >> 1;
      if (b) begin
        lfsr_state = lfsr_state ^ 32'h8020_0003;
      end
      val = {val[30:0], b};
    end
    return val;
  endfunction

  // Y = (77 R + 150 G + 29 B + 128) >> 8
  function automatic logic [7:0] model_y(input logic [7:0] r, input logic [7:0] g,
                                         input logic [7:0] b);
    int unsigned acc;
    acc = 77 * r + 150 * g + 29 * b + 128;
    return 8'(acc >> 8);
  endfunction

  task automatic drive_random_pixel();
    in_r <= 8'(take_bits(8));
    in_g <= 8'(take_bits(8));
    in_b <= 8'(take_bits(8));
  endtask

  // ------------------------------
  // monitor and scoreboard
  // ------------------------------
  // pre-edge values show both handshakes as the DUT saw them
  always @(posedge clk) begin
    if (!rst) begin
      if (in_valid && in_ready) begin
        model_q.push_back(model_y(in_r, in_g, in_b));
        acc_cnt++;
      end
      if (out_valid && out_ready) begin
        res_cnt++;
        check_cnt++;
        assert (model_q.size() > 0) else begin
          errors++;
          $display("%s: a result came out with no pixel pending", test_name);
        end
        if (model_q.size() > 0) begin
          check_cnt++;
          assert (out_y === model_q[0]) else begin
            errors++;
            $display("FAIL %s: expected %0d, actual %0d", test_name, model_q[0], out_y);
          end
          void'(model_q.pop_front());
        end
      end
    end
  end

  // ------------------------------
  // test tasks
  // ------------------------------
  task automatic check_idle_outputs(input string name);
    check_cnt += 2;
    assert (out_valid === 1'b0) else begin
      errors++;
      $display("FAIL %s out_valid: expected 0, actual %b", name, out_valid);
    end
    assert (in_ready === 1'b1) else begin
      errors++;
      $display("FAIL %s in_ready: expected 1, actual %b", name, in_ready);
    end
  endtask

  task automatic reset_test();
    int cycles;
    test_name = "reset";
    cycles = 0;
    // registers may still be x before the first edge under reset
    do begin
      @(posedge clk);
      cycles++;
      if (rst && cycles > 1) begin
        check_idle_outputs("reset");
      end
    end while (rst && cycles < 20);
    if (rst) begin
      timed_out = 1'b1;
      $display("timeout: reset was never released");
      return;
    end
    // this edge closes the first cycle out of reset
    check_idle_outputs("after_reset");
  endtask

  // waits at falling edges so the monitor counts have settled
  task automatic wait_drain(input string name);
    int cycles;
    cycles = 0;
    do begin
      @(negedge clk);
      cycles++;
    end while (res_cnt != acc_cnt && cycles < 200);
    if (res_cnt != acc_cnt) begin
      timed_out = 1'b1;
      $display("timeout in %s: %0d pixels accepted but only %0d results came out",
               name, acc_cnt, res_cnt);
      return;
    end
    check_cnt++;
    assert (model_q.size() == 0) else begin
      errors++;
      $display("%s: scoreboard still holds %0d entries after drain", name, model_q.size());
    end
  endtask

  task automatic send_fixed(input logic [7:0] r, input logic [7:0] g, input logic [7:0] b);
    int cycles;
    bit taken;
    cycles = 0;
    @(posedge clk);
    in_valid <= 1'b1;
    in_r     <= r;
    in_g     <= g;
    in_b     <= b;
    do begin
      @(posedge clk);
      cycles++;
      taken = in_ready;
    end while (!taken && cycles < 50);
    in_valid <= 1'b0;
    if (!taken) begin
      timed_out = 1'b1;
      $display("timeout in %s: fixed pixel was never accepted", test_name);
    end
  endtask

  task automatic corner_test();
    test_name = "fixed_corners";
    @(posedge clk);
    out_ready <= 1'b1;
    send_fixed(8'd0, 8'd0, 8'd0);
    if (!timed_out) send_fixed(8'd255, 8'd255, 8'd255);
    if (!timed_out) send_fixed(8'd255, 8'd0, 8'd0);
    if (!timed_out) send_fixed(8'd0, 8'd255, 8'd0);
    if (!timed_out) send_fixed(8'd0, 8'd0, 8'd255);
    if (timed_out) return;
    wait_drain(test_name);
  endtask

  task automatic run_stream(input string name, input int count, input bit rand_valid,
                            input bit rand_ready);
    int sent;
    int cycles;
    bit want;
    test_name = name;
    sent = 0;
    cycles = 0;
    while (sent < count && cycles < count * 20 + 200) begin
      @(posedge clk);
      cycles++;
      if (in_valid && in_ready) begin
        sent++;
      end
      if (in_valid && !in_ready) begin
        // refused pixel stays on the inputs
      end else if (sent < count) begin
        want = rand_valid ? (take_bits(2) != 0) : 1'b1;
        in_valid <= want;
        if (want) begin
          drive_random_pixel();
        end
      end else begin
        in_valid <= 1'b0;
      end
      out_ready <= rand_ready ? 1'(take_bits(1)) : 1'b1;
    end
    out_ready <= 1'b1;
    if (sent < count) begin
      timed_out = 1'b1;
      $display("timeout in %s: only %0d of %0d pixels accepted", name, sent, count);
      return;
    end
    wait_drain(name);
  endtask

  // sink stalled for 20 cycles with the source pushing all the time
  task automatic back_pressure_test();
    int acc_start;
    int taken;
    bit saw_block;
    test_name = "back_pressure";
    acc_start = acc_cnt;
    saw_block = 1'b0;
    @(posedge clk);
    out_ready <= 1'b0;
    in_valid  <= 1'b1;
    drive_random_pixel();
    for (int c = 0; c < 20; c++) begin
      @(posedge clk);
      if (!in_ready) begin
        saw_block = 1'b1;
      end
      if (c == 19) begin
        in_valid  <= 1'b0;
        out_ready <= 1'b1;
      end else if (in_ready) begin
        drive_random_pixel();
      end
    end
    @(negedge clk);
    taken = acc_cnt - acc_start;
    check_cnt += 2;
    assert (saw_block) else begin
      errors++;
      $display("FAIL %s in_ready_drop: expected 1, actual %b", test_name, saw_block);
    end
    assert (taken <= fifo_depth + mult_lat + 1) else begin
      errors++;
      $display("FAIL %s accepted: expected at most %0d, actual %0d", test_name,
               fifo_depth + mult_lat + 1, taken);
    end
    wait_drain(test_name);
  endtask

  // ------------------------------
  // main sequence
  // ------------------------------
  initial begin
    in_valid   = 1'b0;
    in_r       = 8'd0;
    in_g       = 8'd0;
    in_b       = 8'd0;
    out_ready  = 1'b0;
    lfsr_state = 32'h5b50;
    acc_cnt    = 0;
    res_cnt    = 0;
    check_cnt  = 0;
    errors     = 0;
    timed_out  = 1'b0;
    test_name  = "init";

    reset_test();
    if (!timed_out) corner_test();
    if (!timed_out) run_stream("random_stream", 300, 1'b1, 1'b0);
    if (!timed_out) back_pressure_test();
    if (!timed_out) run_stream("random_stalls", 300, 1'b1, 1'b1);

    $display("checks %0d, errors %0d, timeouts %0d, pixels %0d, results %0d",
             check_cnt, errors, timed_out, acc_cnt, res_cnt);
    if (errors == 0 && !timed_out) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

//--- build.f
luma_pkg.sv
term_if.sv
rgb_coeff_mult.sv
term_fifo.sv
luma_sum.sv
luma_top.sv
tb_clkgen.sv
tb_luma_top.sv
